/* Bender.yml */
package:
  name: proc

sources:
  # Core RTL, package first
  - files:
      - logic/proc_pkg.sv
      - logic/reg_file.sv
      - logic/alu.sv
      - logic/pc_unit.sv
      - logic/mem_port.sv
      - logic/proc_ctrl.sv
      - logic/proc.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/proc_sva.sv
      - bench/proc_tb.sv

/* bench/proc_sva.sv */
`timescale 1ns/1ps

module proc_sva (
  input logic            clk,
  input logic            rst,
  input logic            mem_en,
  input logic            mem_wr,
  input logic            mem_data_valid,
  input proc_pkg::word_t mem_addr,
  input proc_pkg::word_t mem_data_out,
  input logic            hlt,
  input proc_pkg::word_t pc
);
  import proc_pkg::*;

  int fail_count = 0;                       // Failed assertions so far

  //////////////////////////////////////////////////
  // Reset state
  //////////////////////////////////////////////////
  reset_state: assert property (@(posedge clk)
    rst |=> !mem_en && !mem_wr && !hlt && (pc == RESET_PC))
    else begin
      $error("core not idle at the reset PC after a reset edge");
      fail_count++;
    end

  //////////////////////////////////////////////////
  // Memory handshake
  //////////////////////////////////////////////////
  hold_request: assert property (@(posedge clk) disable iff (rst)
    mem_en && !mem_data_valid |=>
      mem_en && $stable(mem_addr) && $stable(mem_wr) && $stable(mem_data_out))
    else begin
      $error("request lines changed before the memory answered");
      fail_count++;
    end

  drop_after_valid: assert property (@(posedge clk) disable iff (rst)
    mem_en && mem_data_valid |=> !mem_en)   // One access per request
    else begin
      $error("mem_en still high the cycle after valid");
      fail_count++;
    end

  write_needs_enable: assert property (@(posedge clk) disable iff (rst)
    mem_wr |-> mem_en)
    else begin
      $error("mem_wr high without mem_en");
      fail_count++;
    end

  //////////////////////////////////////////////////
  // Halt
  //////////////////////////////////////////////////
  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    hlt |=> hlt && !mem_en && $stable(pc))  // Core frozen once halted
    else begin
      $error("core moved or left the halt state");
      fail_count++;
    end

endmodule

bind proc proc_sva u_sva (
  .clk(clk), .rst(rst),
  .mem_en(mem_en), .mem_wr(mem_wr), .mem_data_valid(mem_data_valid),
  .mem_addr(mem_addr), .mem_data_out(mem_data_out),
  .hlt(hlt), .pc(pc)
);

/* bench/proc_tb.sv */
`timescale 1ns/1ps

module proc_tb;
  import proc_pkg::*;

  localparam int    MEM_WORDS  = 256;                   // 512 bytes on address bits 8:1
  localparam int    NUM_STORES = 7;
  localparam int    NUM_INSTR  = 37;
  localparam int    MAX_CYCLES = NUM_INSTR * 15 + 150;  // 6 fetch + 6 data + 3 steps each
  localparam word_t HALT_PC    = 16'h0048;              // HLT sits at instruction 36

  logic  clk = 1'b0;
  logic  rst;
  logic  mem_data_valid;
  word_t mem_data_in;
  logic  mem_en, mem_wr, hlt;
  word_t mem_addr, mem_data_out, pc;

  word_t mem [MEM_WORDS];                   // Shared program and data memory
  int    prog_len;
  logic  pending;                           // Request seen but not answered yet
  int    wait_left;                         // Cycles left before valid
  int    store_idx    = 0;
  int    errors       = 0;
  int    cycles       = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;

  // Stores worked out by hand from the program below in program order
  word_t exp_addr [NUM_STORES] = '{16'h0100, 16'h0102, 16'h0104, 16'h0106,
                                   16'h0108, 16'h010A, 16'h010C};
  word_t exp_data [NUM_STORES] = '{16'h9233, 16'h6DCB, 16'h8007, 16'h9233,
                                   16'h6DCB, 16'h0042, 16'h6DCB};

  proc u_proc (
    .clk(clk), .rst(rst),
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_data_out(mem_data_out),
    .hlt(hlt), .pc(pc)
  );

  always #2 clk = ~clk;                     // 4 ns period

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////
  function automatic word_t alu_instr(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic word_t byte_instr(opcode_t op, reg_idx_t rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic word_t mem_instr(opcode_t op, reg_idx_t rt, reg_idx_t rs, logic [3:0] off);
    return {op, rt, rs, off};               // Byte address rs + 2 * off
  endfunction

  function automatic word_t branch_instr(cond_t cond, logic [8:0] off);
    return {OP_B, cond, off};               // Target PC + 2 + 2 * off
  endfunction

  task automatic append_instr(input word_t w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 16'hF000 | 16'(i);           // Stray fetches decode as HLT
    end
    prog_len = 0;
    append_instr(byte_instr(OP_LLB, 4'd1, 8'h00));       // R1 = 0x0000
    append_instr(byte_instr(OP_LHB, 4'd1, 8'h01));       // R1 = 0x0100 as data base
    append_instr(byte_instr(OP_LLB, 4'd2, 8'h34));
    append_instr(byte_instr(OP_LHB, 4'd2, 8'h12));       // R2 = 0x1234
    append_instr(byte_instr(OP_LLB, 4'd3, 8'hFF));
    append_instr(byte_instr(OP_LHB, 4'd3, 8'h7F));       // R3 = 0x7FFF
    append_instr(alu_instr(OP_ADD, 4'd4, 4'd2, 4'd3));   // 0x9233 with signed overflow
    append_instr(mem_instr(OP_SW, 4'd4, 4'd1, 4'd0));    // [0x0100] = 0x9233
    append_instr(alu_instr(OP_SUB, 4'd5, 4'd3, 4'd2));   // 0x6DCB
    append_instr(mem_instr(OP_SW, 4'd5, 4'd1, 4'd1));    // [0x0102]
    append_instr(alu_instr(OP_XOR, 4'd6, 4'd2, 4'd4));   // 0x8007
    append_instr(mem_instr(OP_SW, 4'd6, 4'd1, 4'd2));    // [0x0104]
    append_instr(mem_instr(OP_LW, 4'd7, 4'd1, 4'd0));    // Reads back 0x9233
    append_instr(mem_instr(OP_SW, 4'd7, 4'd1, 4'd3));    // [0x0106]
    append_instr(byte_instr(OP_LLB, 4'd8, 8'hD0));
    append_instr(byte_instr(OP_LHB, 4'd8, 8'hBA));       // R8 = 0xBAD0 wrong-path marker
    append_instr(alu_instr(OP_ADD, 4'd9, 4'd2, 4'd3));   // Z0 N1 V1
    append_instr(alu_instr(OP_XOR, 4'd10, 4'd2, 4'd3));  // 0x6DCB with N and V kept
    append_instr(branch_instr(COND_OV, 9'd1));           // Taken
    append_instr(mem_instr(OP_SW, 4'd8, 4'd1, 4'd4));    // Skipped
    append_instr(branch_instr(COND_GT, 9'd1));           // N set so not taken
    append_instr(mem_instr(OP_SW, 4'd10, 4'd1, 4'd4));   // [0x0108] = 0x6DCB
    append_instr(alu_instr(OP_SUB, 4'd11, 4'd2, 4'd2));  // Zero result gives Z1 N0 V0
    append_instr(branch_instr(COND_EQ, 9'd1));           // Taken
    append_instr(mem_instr(OP_SW, 4'd8, 4'd1, 4'd5));    // Skipped
    append_instr(branch_instr(COND_GT, 9'd1));           // Z set so not taken
    append_instr(alu_instr(OP_SUB, 4'd12, 4'd3, 4'd2));  // 0x6DCB gives Z0 N0 V0
    append_instr(branch_instr(COND_GT, 9'd1));           // Taken
    append_instr(mem_instr(OP_SW, 4'd8, 4'd1, 4'd5));    // Skipped
    append_instr(branch_instr(COND_EQ, 9'd1));           // Not taken
    append_instr(branch_instr(COND_UNCOND, 9'd1));       // Always taken
    append_instr(mem_instr(OP_SW, 4'd8, 4'd1, 4'd5));    // Skipped
    append_instr({OP_PCS, 4'd13, 8'h00});                // At 0x0040 so R13 = 0x0042
    append_instr(mem_instr(OP_SW, 4'd13, 4'd1, 4'd5));   // [0x010A] = 0x0042
    append_instr(branch_instr(COND_OV, 9'd1));           // V clear so not taken
    append_instr(mem_instr(OP_SW, 4'd12, 4'd1, 4'd6));   // [0x010C] = 0x6DCB
    append_instr({OP_HLT, 12'h000});
  endtask

  //////////////////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got == exp) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic record_store();
    assert (store_idx < NUM_STORES) else begin
      $display("Unexpected store of 0x%h to 0x%h after the last expected store",
               mem_data_out, mem_addr);
      errors++;
    end
    if (store_idx < NUM_STORES) begin
      check_word("mem_addr", mem_addr, exp_addr[store_idx]);
      check_word("mem_data_out", mem_data_out, exp_data[store_idx]);
    end
    store_idx++;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors > errs_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // Returns early if the core halts before the stores arrive
  task automatic wait_for_stores(input int count);
    while ((store_idx < count) && !hlt) begin
      @(negedge clk);
    end
    assert (store_idx >= count) else begin
      $display("Core halted after %0d stores, expected at least %0d", store_idx, count);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Memory model with a random answer delay
  //////////////////////////////////////////////////
  initial begin
    int delay;
    void'($urandom(60));
    mem_data_valid = 1'b0;
    mem_data_in    = '0;
    pending        = 1'b0;
    wait_left      = 0;
    forever begin
      @(posedge clk);
      if (rst) begin
        mem_data_valid <= 1'b0;
        pending        <= 1'b0;
      end else if (mem_data_valid) begin
        mem_data_valid <= 1'b0;             // Access completes on this edge
        pending        <= 1'b0;
        if (mem_wr) begin
          record_store();
          mem[mem_addr[8:1]] <= mem_data_out;
        end
      end else if (mem_en) begin
        delay = pending ? wait_left : int'($urandom % 4);  // 0 to 3 idle cycles
        if (delay == 0) begin
          mem_data_valid <= 1'b1;
          mem_data_in    <= mem[mem_addr[8:1]];
        end else begin
          wait_left <= delay - 1;
        end
        pending <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: core did not halt within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    int errs_at_start;
    int total;
    rst = 1'b1;
    load_program();
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    errs_at_start = errors;
    @(negedge clk);                         // First cycle out of reset
    check_word("mem_en", mem_en, 0);
    check_word("mem_wr", mem_wr, 0);
    check_word("hlt", hlt, 0);
    check_word("pc", pc, RESET_PC);
    report_test("reset state", errs_at_start);

    errs_at_start = errors;
    wait_for_stores(3);
    report_test("arithmetic and byte loads", errs_at_start);
    errs_at_start = errors;
    wait_for_stores(4);
    report_test("memory round trip", errs_at_start);
    errs_at_start = errors;
    wait_for_stores(NUM_STORES);
    report_test("branches and pcs", errs_at_start);

    errs_at_start = errors;
    while (!hlt) begin
      @(negedge clk);
    end
    assert (store_idx == NUM_STORES) else begin
      $display("Core halted after %0d of %0d expected stores", store_idx, NUM_STORES);
      errors++;
    end
    check_word("pc", pc, HALT_PC);
    repeat (20) begin
      @(negedge clk);
      check_word("hlt", hlt, 1);
      check_word("mem_en", mem_en, 0);      // No fetch after halt
    end
    report_test("halt", errs_at_start);

    tests_run++;
    if (u_proc.u_sva.fail_count > 0) begin
      tests_failed++;
      $display("test bound assertions: failed %0d times", u_proc.u_sva.fail_count);
    end else begin
      $display("test bound assertions: ok");
    end

    total = errors + u_proc.u_sva.fail_count;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic              clk,
  input  logic              rst,
  input  proc_pkg::alu_op_t op,
  input  logic              flag_load,      // High in EXECUTE of ADD, SUB, XOR
  input  logic              xor_only,       // Keep N and V
  input  proc_pkg::word_t   a,              // rs
  input  proc_pkg::word_t   b,              // rt, or old rd for byte loads
  input  proc_pkg::word_t   imm,            // Whole instruction word
  output proc_pkg::word_t   result,
  output proc_pkg::flags_t  flags
);
  import proc_pkg::*;

  word_t sum, diff;
  word_t mem_off;                           // Sign extended offset, times two
  word_t mem_addr;
  word_t res_nxt;
  logic  ovf;

  assign sum      = a + b;                  // Wraps, no saturation
  assign diff     = a - b;
  assign mem_off  = {{11{imm[3]}}, imm[3:0], 1'b0};
  assign mem_addr = {a[WORD_W-1:1], 1'b0} + mem_off;

  always_comb begin
    res_nxt = sum;
    ovf     = 1'b0;
    case (op)
      ALU_ADD: begin
        res_nxt = sum;
        ovf     = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_SUB: begin
        res_nxt = diff;
        ovf     = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_XOR:  res_nxt = a ^ b;
      ALU_LLB:  res_nxt = {b[WORD_W-1:8], imm[7:0]};   // Replace low byte
      ALU_LHB:  res_nxt = {imm[7:0], b[7:0]};          // Replace high byte
      ALU_ADDR: res_nxt = mem_addr;
      default:  res_nxt = sum;
    endcase
  end

  // Inputs are steady for the whole instruction, so the result tracks every cycle
  always_ff @(posedge clk) begin
    result <= res_nxt;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flag_load) begin
      flags[FLAG_Z] <= (res_nxt == '0);
      if (!xor_only) begin
        flags[FLAG_N] <= res_nxt[WORD_W-1];
        flags[FLAG_V] <= ovf;
      end
    end
  end

endmodule

/* logic/mem_port.sv */
`timescale 1ns/1ps

module mem_port (
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_req,        // Level request in FETCH
  input  logic            data_req,         // Level request in MEMORY
  input  logic            data_wr,          // SW when set
  input  proc_pkg::word_t pc,
  input  proc_pkg::word_t data_addr,
  input  proc_pkg::word_t store_data,
  input  logic            mem_data_valid,
  input  proc_pkg::word_t mem_data_in,
  input  logic            ir_load,          // Read data goes to the instruction register
  output logic            mem_en,
  output logic            mem_wr,
  output proc_pkg::word_t mem_addr,
  output proc_pkg::word_t mem_data_out,
  output logic            mem_done,
  output proc_pkg::word_t instr,
  output proc_pkg::word_t load_data
);

  assign mem_done = mem_en && mem_data_valid;       // Completing edge

  // Request lines, raised once and held until valid
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_en <= 1'b0;
      mem_wr <= 1'b0;
    end else if (mem_done) begin
      mem_en <= 1'b0;                               // Drops the cycle after valid
      mem_wr <= 1'b0;
    end else if (!mem_en && (fetch_req || data_req)) begin
      mem_en <= 1'b1;
      mem_wr <= data_req && data_wr;
    end
  end

  // Address and store data frozen while a request is open
  always_ff @(posedge clk) begin
    if (!mem_en) begin
      mem_addr     <= fetch_req ? pc : data_addr;
      mem_data_out <= store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_done && ir_load) begin
      instr <= mem_data_in;
    end
    if (mem_done && !ir_load && !mem_wr) begin
      load_data <= mem_data_in;                     // LW only
    end
  end

endmodule

/* logic/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             pc_load,         // Step or redirect this edge
  input  logic             is_branch,       // Current instruction is B
  input  proc_pkg::cond_t  cond,            // ccc field
  input  logic [8:0]       offset,          // Signed word offset
  input  proc_pkg::flags_t flags,
  output proc_pkg::word_t  pc,
  output proc_pkg::word_t  pc_plus2,
  output logic             taken
);
  import proc_pkg::*;

  word_t target;
  logic  cond_met;
  logic  z, n, v;

  assign z = flags[FLAG_Z];
  assign n = flags[FLAG_N];
  assign v = flags[FLAG_V];

  assign pc_plus2 = pc + PC_STEP;
  assign target   = pc_plus2 + {{6{offset[8]}}, offset, 1'b0};  // Relative to next PC

  //////////////////////////////////////////////////
  // Condition check against the flag register
  //////////////////////////////////////////////////
  always_comb begin
    case (cond)
      COND_NE: cond_met = !z;
      COND_EQ: cond_met = z;
      COND_GT: cond_met = !z && !n;
      COND_LT: cond_met = n;
      COND_GE: cond_met = (!z && !n) || z;
      COND_LE: cond_met = n || z;
      COND_OV: cond_met = v;
      default: cond_met = 1'b1;             // Unconditional
    endcase
  end

  assign taken = is_branch && cond_met;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (pc_load) begin
      pc <= taken ? target : pc_plus2;
    end
  end

endmodule

/* logic/proc.sv */
`timescale 1ns/1ps

module proc (
  input  logic            clk,              // System clock
  input  logic            rst,              // Synchronous, active high
  input  logic            mem_data_valid,   // Memory finished the access
  input  proc_pkg::word_t mem_data_in,      // Read data from memory
  output logic            mem_en,           // Access request
  output proc_pkg::word_t mem_addr,         // Access address
  output logic            mem_wr,           // Write strobe, only with mem_en
  output proc_pkg::word_t mem_data_out,     // Store data
  output logic            hlt,              // Core stopped on HLT
  output proc_pkg::word_t pc                // Current program counter
);
  import proc_pkg::*;

  word_t    instr;                          // Instruction register
  word_t    load_data;                      // LW result from memory
  word_t    rdata_a, rdata_b;               // Register file read data
  word_t    alu_result;                     // Registered ALU output
  word_t    pc_plus2;                       // Link value for PCS
  word_t    wdata;                          // Write-back data
  flags_t   flags;                          // Z, N, V from the ALU
  alu_op_t  alu_op;
  wb_sel_t  wb_sel;
  reg_idx_t rs_b;                           // Second read register, picked by decode
  logic     fetch_req, data_req, data_wr;
  logic     ir_load, flag_load, xor_only;
  logic     reg_we, is_branch, pc_load;
  logic     mem_done, taken;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////
  proc_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .instr(instr), .mem_done(mem_done), .taken(taken),
    .fetch_req(fetch_req), .data_req(data_req), .data_wr(data_wr),
    .ir_load(ir_load), .alu_op(alu_op), .flag_load(flag_load), .xor_only(xor_only),
    .reg_we(reg_we), .rs_b(rs_b), .wb_sel(wb_sel), .is_branch(is_branch),
    .pc_load(pc_load), .hlt(hlt)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  reg_file u_regs (
    .clk(clk), .rst(rst),
    .rs_a(instr[7:4]), .rs_b(rs_b), .rd(instr[11:8]),  // rs, rt/rd field, rd
    .we(reg_we), .wdata(wdata),
    .rdata_a(rdata_a), .rdata_b(rdata_b)
  );

  alu u_alu (
    .clk(clk), .rst(rst),
    .op(alu_op), .flag_load(flag_load), .xor_only(xor_only),
    .a(rdata_a), .b(rdata_b), .imm(instr),          // ALU picks its own immediate field
    .result(alu_result), .flags(flags)
  );

  pc_unit u_pc (
    .clk(clk), .rst(rst),
    .pc_load(pc_load), .is_branch(is_branch),
    .cond(cond_t'(instr[11:9])), .offset(instr[8:0]), .flags(flags),
    .pc(pc), .pc_plus2(pc_plus2), .taken(taken)
  );

  mem_port u_mem (
    .clk(clk), .rst(rst),
    .fetch_req(fetch_req), .data_req(data_req), .data_wr(data_wr),
    .pc(pc), .data_addr(alu_result), .store_data(rdata_b),  // SW data from rt
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in), .ir_load(ir_load),
    .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_data_out(mem_data_out),
    .mem_done(mem_done), .instr(instr), .load_data(load_data)
  );

  // Write-back source for LW, PCS or an ALU result
  always_comb begin
    case (wb_sel)
      WB_LOAD: wdata = load_data;
      WB_PC2:  wdata = pc_plus2;                    // PC has not stepped yet in WRITEBACK
      default: wdata = alu_result;
    endcase
  end

endmodule

/* logic/proc_ctrl.sv */
`timescale 1ns/1ps

module proc_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  proc_pkg::word_t     instr,        // Current instruction word
  input  logic                mem_done,     // Valid seen on this edge
  input  logic                taken,        // Branch condition met
  output logic                fetch_req,
  output logic                data_req,
  output logic                data_wr,
  output logic                ir_load,
  output proc_pkg::alu_op_t   alu_op,
  output logic                flag_load,
  output logic                xor_only,     // Only Z follows XOR
  output logic                reg_we,
  output proc_pkg::reg_idx_t  rs_b,
  output proc_pkg::wb_sel_t   wb_sel,
  output logic                is_branch,
  output logic                pc_load,
  output logic                hlt
);
  import proc_pkg::*;

  ctrl_state_t state, state_nxt;
  opcode_t     opcode;
  logic        is_alu_op;                   // Sets flags
  logic        is_mem_op;                   // Needs the MEMORY step
  logic        writes_reg;

  assign opcode = opcode_t'(instr[15:12]);

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////
  always_comb begin
    alu_op     = ALU_ADD;
    is_alu_op  = 1'b0;
    is_mem_op  = 1'b0;
    writes_reg = 1'b0;
    wb_sel     = WB_ALU;
    rs_b       = instr[3:0];                // rt for register ops
    case (opcode)
      OP_ADD, OP_SUB, OP_XOR: begin
        alu_op     = (opcode == OP_ADD) ? ALU_ADD :
                     (opcode == OP_SUB) ? ALU_SUB : ALU_XOR;
        is_alu_op  = 1'b1;
        writes_reg = 1'b1;
      end
      OP_LW, OP_SW: begin
        alu_op     = ALU_ADDR;              // Base plus scaled offset
        is_mem_op  = 1'b1;
        writes_reg = (opcode == OP_LW);
        wb_sel     = WB_LOAD;
        rs_b       = instr[11:8];           // Store data register
      end
      OP_LLB, OP_LHB: begin
        alu_op     = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
        writes_reg = 1'b1;
        rs_b       = instr[11:8];           // Old value of rd, one byte kept
      end
      OP_PCS: begin
        writes_reg = 1'b1;
        wb_sel     = WB_PC2;
      end
      default: begin
      end                                   // B, HLT and unused codes write nothing
    endcase
  end

  //////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_FETCH: begin
        if (mem_done) state_nxt = ST_DECODE;            // Instruction captured
      end
      ST_DECODE:    state_nxt = ST_EXECUTE;
      ST_EXECUTE:   state_nxt = is_mem_op ? ST_MEMORY : ST_WRITEBACK;
      ST_MEMORY: begin
        if (mem_done) state_nxt = ST_WRITEBACK;
      end
      ST_WRITEBACK: state_nxt = (opcode == OP_HLT) ? ST_HALTED : ST_FETCH;
      default:      state_nxt = ST_HALTED;              // Stays here until reset
    endcase
  end

  assign fetch_req = (state == ST_FETCH);
  assign ir_load   = (state == ST_FETCH);
  assign data_req  = (state == ST_MEMORY);
  assign data_wr   = (opcode == OP_SW);
  assign flag_load = (state == ST_EXECUTE) && is_alu_op;
  assign xor_only  = (opcode == OP_XOR);
  assign reg_we    = (state == ST_WRITEBACK) && writes_reg;
  assign is_branch = (opcode == OP_B);
  assign hlt       = (state == ST_HALTED);

  // Taken branch redirects in EXECUTE, everything else steps in WRITEBACK
  assign pc_load = ((state == ST_EXECUTE) && is_branch && taken) ||
                   ((state == ST_WRITEBACK) && (opcode != OP_HLT) && !(is_branch && taken));

endmodule

/* logic/proc_pkg.sv */
package proc_pkg;

  //////////////////////////////////////////////////
  // Widths and reset values
  //////////////////////////////////////////////////
  localparam int WORD_W    = 16;                  // Data, address and instruction width
  localparam int NUM_REGS  = 16;                  // Register file depth
  localparam int REG_IDX_W = $clog2(NUM_REGS);    // Register number width

  typedef logic [WORD_W-1:0]    word_t;           // One machine word
  typedef logic [REG_IDX_W-1:0] reg_idx_t;        // Register number
  typedef logic [2:0]           flags_t;          // {Z, N, V}

  localparam int FLAG_Z = 2;                      // Zero flag position
  localparam int FLAG_N = 1;                      // Negative flag position
  localparam int FLAG_V = 0;                      // Signed overflow flag position

  localparam word_t RESET_PC = '0;                // First fetch address
  localparam word_t PC_STEP  = 16'd2;             // Byte addressed, two per instruction

  //////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    OP_ADD = 4'b0000,
    OP_SUB = 4'b0001,
    OP_XOR = 4'b0010,
    OP_LW  = 4'b1000,
    OP_SW  = 4'b1001,
    OP_LLB = 4'b1010,
    OP_LHB = 4'b1011,
    OP_B   = 4'b1100,
    OP_PCS = 4'b1110,
    OP_HLT = 4'b1111
  } opcode_t;

  typedef enum logic [2:0] {
    COND_NE     = 3'b000,
    COND_EQ     = 3'b001,
    COND_GT     = 3'b010,
    COND_LT     = 3'b011,
    COND_GE     = 3'b100,
    COND_LE     = 3'b101,
    COND_OV     = 3'b110,
    COND_UNCOND = 3'b111
  } cond_t;

  //////////////////////////////////////////////////
  // Internal control encodings
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_LLB, ALU_LHB, ALU_ADDR} alu_op_t;

  typedef enum logic [2:0] {
    ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK, ST_HALTED
  } ctrl_state_t;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC2} wb_sel_t;  // Write-back source

endpackage

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  proc_pkg::reg_idx_t rs_a,          // First read port
  input  proc_pkg::reg_idx_t rs_b,          // Second read port
  input  proc_pkg::reg_idx_t rd,            // Write port
  input  logic               we,
  input  proc_pkg::word_t    wdata,
  output proc_pkg::word_t    rdata_a,
  output proc_pkg::word_t    rdata_b
);
  import proc_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin    // R0 is never written
      regs[rd] <= wdata;
    end
  end

  // Asynchronous reads, R0 forced to zero
  assign rdata_a = (rs_a == '0) ? '0 : regs[rs_a];
  assign rdata_b = (rs_b == '0) ? '0 : regs[rs_b];

endmodule

/* tb.f */
logic/proc_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/mem_port.sv
logic/proc_ctrl.sv
logic/proc.sv
bench/proc_sva.sv
bench/proc_tb.sv
